/* verilog/sdram_pkg.sv */
// Shared CSR map, field types, SDRAM command encodings and refresh FSM states.
package sdram_pkg;

	// ########################################################################
	// CSR map
	// ########################################################################

	localparam logic [3:0] CSR_BANK = 4'h0; // Matched against csr_a[13:10].

	localparam logic [1:0] REG_MODE = 2'd0; // Bypass, SDRAM reset, CKE.
	localparam logic [1:0] REG_CMD  = 2'd1; // Raw software command.
	localparam logic [1:0] REG_PHY  = 2'd3; // Delay line and DQS phase shift.
	localparam logic [1:0] REG_TIM  = 2'd2; // Timing parameters.

	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;

	// ########################################################################
	// SDRAM command bus
	// ########################################################################

	typedef logic [12:0] sdram_adr_t; // Row or column.
	typedef logic [1:0]  sdram_ba_t;

	// Command lines all active low.
	typedef struct packed {
		logic       cs_n;
		logic       ras_n;
		logic       cas_n;
		logic       we_n;
		sdram_adr_t adr;
		sdram_ba_t  ba;
	} sdram_cmd_t;

	// Encodings as {cs_n, ras_n, cas_n, we_n}.
	localparam logic [3:0] CMD_NOP           = 4'b1111;
	localparam logic [3:0] CMD_PRECHARGE_ALL = 4'b0010;
	localparam logic [3:0] CMD_AUTO_REFRESH  = 4'b0001;

	localparam sdram_adr_t ADR_PRECHARGE_ALL = 13'h0400; // A10 selects all banks.

	// ########################################################################
	// Timing parameters, packed in CSR bit order
	// ########################################################################

	typedef struct packed {
		logic [1:0]  wr;   // Write recovery.
		logic [3:0]  rfc;  // Refresh to next command.
		logic [10:0] refi; // Refresh interval.
		logic        cas;  // CAS latency, 0 means 2.
		logic [2:0]  rcd;  // Activate to read or write.
		logic [2:0]  rp;   // Precharge period.
	} tim_cfg_t;

	localparam tim_cfg_t TIM_RESET = '{wr: 2'd2, rfc: 4'd6, refi: 11'd620, cas: 1'b0,
		rcd: 3'd2, rp: 3'd2};

	// Auto-refresh scheduler states.
	typedef enum logic [2:0] {
		COUNT,
		PRECHARGE,
		WAIT_RP,
		REFRESH,
		WAIT_RFC
	} refresh_state_t;

endpackage

/* verilog/sdram_ctlif.sv */
// CSR register bank for controller mode, software command, timings and PHY strobes.
`timescale 1ns/1ps

module sdram_ctlif (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  sdram_pkg::csr_addr_t csr_a,
	input  logic                 csr_we,
	input  sdram_pkg::csr_data_t csr_di,
	output sdram_pkg::csr_data_t csr_do,

	output logic                 bypass,
	output logic                 sdram_rst,
	output logic                 cke,

	output sdram_pkg::sdram_cmd_t sw_cmd,
	output sdram_pkg::tim_cfg_t   tim,

	output logic                 idelay_rst,
	output logic                 idelay_ce,
	output logic                 idelay_inc,
	output logic                 idelay_cal,
	output logic                 dqs_psen,
	output logic                 dqs_psincdec,

	input  logic                 dqs_psdone,
	input  logic [1:0]           pll_stat
);

	import sdram_pkg::*;

	// ########################################################################
	// Address decode
	// ########################################################################

	logic       csr_sel;
	logic [1:0] reg_idx;
	logic       wr_mode;
	logic       wr_cmd;
	logic       wr_tim;
	logic       wr_phy;

	assign csr_sel = (csr_a[13:10] == CSR_BANK); // Bank match.
	assign reg_idx = csr_a[1:0];

	assign wr_mode = csr_sel & csr_we & (reg_idx == REG_MODE);
	assign wr_cmd  = csr_sel & csr_we & (reg_idx == REG_CMD);
	assign wr_tim  = csr_sel & csr_we & (reg_idx == REG_TIM);
	assign wr_phy  = csr_sel & csr_we & (reg_idx == REG_PHY);

	// ########################################################################
	// Mode and timing registers
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bypass    <= 1'b1; // Software owns the bus.
			sdram_rst <= 1'b1;
			cke       <= 1'b0;
		end else if (wr_mode) begin
			bypass    <= csr_di[0];
			sdram_rst <= csr_di[1];
			cke       <= csr_di[2];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			tim <= TIM_RESET;
		else if (wr_tim)
			tim <= tim_cfg_t'(csr_di[23:0]); // Same layout as the struct.
	end

	// ########################################################################
	// Software command
	// ########################################################################

	logic [3:0] cmd_lines; // {cs_n, ras_n, cas_n, we_n}.
	sdram_adr_t cmd_adr;   // Sticky for readback.
	sdram_ba_t  cmd_ba;

	always_ff @(posedge sys_clk) begin
		cmd_lines <= CMD_NOP; // Lines drop back to NOP after one cycle.
		if (sys_rst) begin
			cmd_adr <= '0;
			cmd_ba  <= '0;
		end else if (wr_cmd) begin
			// CSR bits are active high, in order cs, we, cas, ras.
			cmd_lines <= ~{csr_di[0], csr_di[3], csr_di[2], csr_di[1]};
			cmd_adr   <= csr_di[16:4];
			cmd_ba    <= csr_di[18:17];
		end
	end

	assign sw_cmd = {cmd_lines, cmd_adr, cmd_ba};

	// ########################################################################
	// PHY strobes and status
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			idelay_rst   <= 1'b0;
			idelay_ce    <= 1'b0;
			idelay_inc   <= 1'b0;
			idelay_cal   <= 1'b0;
			dqs_psen     <= 1'b0;
			dqs_psincdec <= 1'b0;
		end else begin
			idelay_rst   <= wr_phy & csr_di[0]; // Single-cycle pulses.
			idelay_ce    <= wr_phy & csr_di[1];
			idelay_inc   <= wr_phy & csr_di[2];
			dqs_psen     <= wr_phy & csr_di[4];
			dqs_psincdec <= wr_phy & csr_di[5];
			if (wr_phy)
				idelay_cal <= csr_di[3]; // Level, holds until rewritten.
		end
	end

	// Phase shift done flag.
	logic psready;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			psready <= 1'b0;
		else if (dqs_psdone)
			psready <= 1'b1;
		else if (dqs_psen)
			psready <= 1'b0; // New shift under way.
	end

	// Two-flop synchronizer for the PLL status.
	logic [1:0] pll_meta;
	logic [1:0] pll_sync;

	always_ff @(posedge sys_clk) begin
		pll_meta <= pll_stat;
		pll_sync <= pll_meta;
	end

	// ########################################################################
	// Readback
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0; // Zero when not selected.
			if (csr_sel) begin
				case (reg_idx)
					REG_MODE: csr_do <= {29'd0, cke, sdram_rst, bypass};
					REG_CMD:  csr_do <= {13'd0, cmd_ba, cmd_adr, 4'h0};
					REG_TIM:  csr_do <= {8'd0, tim};
					REG_PHY:  csr_do <= {23'd0, pll_sync, psready, 6'd0};
					default:  csr_do <= '0;
				endcase
			end
		end
	end

endmodule

/* verilog/sdram_refresh.sv */
// Auto-refresh scheduler with tREFI interval, PRECHARGE ALL, tRP, AUTO REFRESH and tRFC.
`timescale 1ns/1ps

module sdram_refresh (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  logic                  bypass,
	input  logic                  sdram_rst,
	input  sdram_pkg::tim_cfg_t   tim,

	output sdram_pkg::sdram_cmd_t ref_cmd
);

	import sdram_pkg::*;

	refresh_state_t state;
	logic [10:0]    cnt;  // Shared by tREFI, tRP and tRFC.
	logic           hold; // Software owns the bus or SDRAM in reset.

	assign hold = bypass | sdram_rst;

	// ########################################################################
	// Scheduler FSM
	// ########################################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= COUNT;
			cnt   <= TIM_RESET.refi;
		end else if (hold) begin
			state <= COUNT; // Park with the interval preloaded.
			cnt   <= tim.refi;
		end else begin
			case (state)
				COUNT: begin
					if (cnt == 11'd0)
						state <= PRECHARGE;
					else
						cnt <= cnt - 11'd1;
				end
				PRECHARGE: begin
					// Zero tRP skips the wait entirely.
					if (tim.rp == 3'd0) begin
						state <= REFRESH;
					end else begin
						state <= WAIT_RP;
						cnt   <= 11'(tim.rp) - 11'd1;
					end
				end
				WAIT_RP: begin
					if (cnt == 11'd0)
						state <= REFRESH;
					else
						cnt <= cnt - 11'd1;
				end
				REFRESH: begin
					if (tim.rfc == 4'd0) begin
						state <= COUNT;
						cnt   <= tim.refi;
					end else begin
						state <= WAIT_RFC;
						cnt   <= 11'(tim.rfc) - 11'd1;
					end
				end
				WAIT_RFC: begin
					if (cnt == 11'd0) begin
						state <= COUNT;
						cnt   <= tim.refi; // Next interval.
					end else begin
						cnt <= cnt - 11'd1;
					end
				end
				default: begin
					state <= COUNT;
					cnt   <= tim.refi;
				end
			endcase
		end
	end

	// ########################################################################
	// Command decode
	// ########################################################################

	always_comb begin
		ref_cmd = {CMD_NOP, sdram_adr_t'(0), sdram_ba_t'(0)};
		case (state)
			PRECHARGE: ref_cmd = {CMD_PRECHARGE_ALL, ADR_PRECHARGE_ALL, sdram_ba_t'(0)};
			REFRESH:   ref_cmd = {CMD_AUTO_REFRESH, sdram_adr_t'(0), sdram_ba_t'(0)};
			default:   ref_cmd = {CMD_NOP, sdram_adr_t'(0), sdram_ba_t'(0)};
		endcase
	end

endmodule

/* verilog/sdram_cmd_out.sv */
// Pad command stage selecting software or refresh command, with registered pads and CKE.
`timescale 1ns/1ps

module sdram_cmd_out (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  logic                  bypass,
	input  logic                  sdram_rst,
	input  logic                  cke,

	input  sdram_pkg::sdram_cmd_t sw_cmd,
	input  sdram_pkg::sdram_cmd_t ref_cmd,

	output sdram_pkg::sdram_cmd_t pad_cmd,
	output logic                  sdram_cke
);

	import sdram_pkg::*;

	sdram_cmd_t next_cmd;

	// ########################################################################
	// Source select
	// ########################################################################

	always_comb begin
		if (sdram_rst)
			next_cmd = {CMD_NOP, sdram_adr_t'(0), sdram_ba_t'(0)}; // Hold idle.
		else if (bypass)
			next_cmd = sw_cmd; // Software drives the bus.
		else
			next_cmd = ref_cmd; // Scheduler owns it.
	end

	// ########################################################################
	// Pad flops
	// ########################################################################

	// Command lines and CKE.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pad_cmd.cs_n  <= 1'b1;
			pad_cmd.ras_n <= 1'b1;
			pad_cmd.cas_n <= 1'b1;
			pad_cmd.we_n  <= 1'b1;
			sdram_cke     <= 1'b0;
		end else begin
			pad_cmd.cs_n  <= next_cmd.cs_n;
			pad_cmd.ras_n <= next_cmd.ras_n;
			pad_cmd.cas_n <= next_cmd.cas_n;
			pad_cmd.we_n  <= next_cmd.we_n;
			sdram_cke     <= cke;
		end
	end

	// Address and bank.
	always_ff @(posedge sys_clk) begin
		pad_cmd.adr <= next_cmd.adr;
		pad_cmd.ba  <= next_cmd.ba;
	end

endmodule

/* verilog/sdram_ctrl_top.sv */
// SDRAM control top level chaining CSR bank, refresh scheduler and pad command stage.
`timescale 1ns/1ps

module sdram_ctrl_top (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  sdram_pkg::csr_addr_t  csr_a,
	input  logic                  csr_we,
	input  sdram_pkg::csr_data_t  csr_di,
	output sdram_pkg::csr_data_t  csr_do,

	input  logic                  dqs_psdone,
	input  logic [1:0]            pll_stat,

	output logic                  idelay_rst,
	output logic                  idelay_ce,
	output logic                  idelay_inc,
	output logic                  idelay_cal,
	output logic                  dqs_psen,
	output logic                  dqs_psincdec,

	output sdram_pkg::tim_cfg_t   tim,

	output logic                  sdram_cke,
	output logic                  sdram_cs_n,
	output logic                  sdram_ras_n,
	output logic                  sdram_cas_n,
	output logic                  sdram_we_n,
	output sdram_pkg::sdram_adr_t sdram_adr,
	output sdram_pkg::sdram_ba_t  sdram_ba
);

	import sdram_pkg::*;

	logic       bypass;
	logic       sdram_rst;
	logic       cke;
	sdram_cmd_t sw_cmd;
	sdram_cmd_t ref_cmd;
	sdram_cmd_t pad_cmd;

	// Stage 1, CSR bank.
	sdram_ctlif ctlif_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a        (csr_a),
		.csr_we       (csr_we),
		.csr_di       (csr_di),
		.csr_do       (csr_do),
		.bypass       (bypass),
		.sdram_rst    (sdram_rst),
		.cke          (cke),
		.sw_cmd       (sw_cmd),
		.tim          (tim),
		.idelay_rst   (idelay_rst),
		.idelay_ce    (idelay_ce),
		.idelay_inc   (idelay_inc),
		.idelay_cal   (idelay_cal),
		.dqs_psen     (dqs_psen),
		.dqs_psincdec (dqs_psincdec),
		.dqs_psdone   (dqs_psdone),
		.pll_stat     (pll_stat)
	);

	// Stage 2, refresh scheduler.
	sdram_refresh refresh_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.bypass    (bypass),
		.sdram_rst (sdram_rst),
		.tim       (tim),
		.ref_cmd   (ref_cmd)
	);

	// Stage 3, pad registers.
	sdram_cmd_out cmd_out_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.bypass    (bypass),
		.sdram_rst (sdram_rst),
		.cke       (cke),
		.sw_cmd    (sw_cmd),
		.ref_cmd   (ref_cmd),
		.pad_cmd   (pad_cmd),
		.sdram_cke (sdram_cke)
	);

	// Unpack onto the pins.
	assign sdram_cs_n  = pad_cmd.cs_n;
	assign sdram_ras_n = pad_cmd.ras_n;
	assign sdram_cas_n = pad_cmd.cas_n;
	assign sdram_we_n  = pad_cmd.we_n;
	assign sdram_adr   = pad_cmd.adr;
	assign sdram_ba    = pad_cmd.ba;

endmodule

/* verif/sdram_ctrl_properties.sv */
// Concurrent assertions on idle pads in SDRAM reset, refresh in bypass and PHY strobe width.
`timescale 1ns/1ps

module sdram_ctrl_properties (
	input logic                  sys_clk,
	input logic                  sys_rst,
	input logic                  bypass,
	input logic                  sdram_rst,
	input sdram_pkg::sdram_cmd_t ref_cmd,
	input logic                  sdram_cs_n,
	input logic                  sdram_ras_n,
	input logic                  sdram_cas_n,
	input logic                  sdram_we_n,
	input logic                  dqs_psen,
	input logic                  idelay_ce
);

	import sdram_pkg::*;

	int unsigned err_count = 0; // Failed assertions so far.

	logic [3:0] pad_lines; // {cs_n, ras_n, cas_n, we_n} on the pins.
	logic [3:0] ref_lines; // Same, from the scheduler.

	assign pad_lines = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};
	assign ref_lines = {ref_cmd.cs_n, ref_cmd.ras_n, ref_cmd.cas_n, ref_cmd.we_n};

	// ########################################################################
	// Pad and scheduler rules
	// ########################################################################

	// Pads lag the mode register by one flop.
	pads_idle_in_reset: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(sdram_rst && $past(sdram_rst)) |-> (pad_lines == CMD_NOP))
	else begin
		$error("Pad command is not NOP while the SDRAM reset is held.");
		err_count++;
	end

	// Scheduler parks one cycle after bypass rises.
	no_refresh_in_bypass: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(bypass && $past(bypass)) |-> (ref_lines == CMD_NOP))
	else begin
		$error("Refresh command issued while in bypass.");
		err_count++;
	end

	// ########################################################################
	// PHY strobes
	// ########################################################################

	psen_single_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		dqs_psen |=> !dqs_psen)
	else begin
		$error("dqs_psen high for two cycles in a row.");
		err_count++;
	end

	idelay_ce_single_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		idelay_ce |=> !idelay_ce)
	else begin
		$error("idelay_ce high for two cycles in a row.");
		err_count++;
	end

endmodule

/* verif/tb_sdram_ctrl.sv */
// Testbench with clock, reset, seeded random CSR traffic, register and pad model, compare tasks.
`timescale 1ns/1ps

module tb_sdram_ctrl;

	import sdram_pkg::*;

	// ########################################################################
	// DUT, clock and assertions
	// ########################################################################

	logic       sys_clk    = 1'b0;
	logic       sys_rst    = 1'b1; // Held from time zero.
	csr_addr_t  csr_a      = '0;
	logic       csr_we     = 1'b0;
	csr_data_t  csr_di     = '0;
	logic       dqs_psdone = 1'b0;
	logic [1:0] pll_stat   = 2'b00;

	csr_data_t  csr_do;
	logic       idelay_rst;
	logic       idelay_ce;
	logic       idelay_inc;
	logic       idelay_cal;
	logic       dqs_psen;
	logic       dqs_psincdec;
	tim_cfg_t   tim;
	logic       sdram_cke;
	logic       sdram_cs_n;
	logic       sdram_ras_n;
	logic       sdram_cas_n;
	logic       sdram_we_n;
	sdram_adr_t sdram_adr;
	sdram_ba_t  sdram_ba;

	sdram_ctrl_top dut_i (.*);

	bind sdram_ctrl_top sdram_ctrl_properties props_i (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.bypass      (bypass),
		.sdram_rst   (sdram_rst),
		.ref_cmd     (ref_cmd),
		.sdram_cs_n  (sdram_cs_n),
		.sdram_ras_n (sdram_ras_n),
		.sdram_cas_n (sdram_cas_n),
		.sdram_we_n  (sdram_we_n),
		.dqs_psen    (dqs_psen),
		.idelay_ce   (idelay_ce)
	);

	always #5 sys_clk = ~sys_clk; // 100 MHz.

	// ########################################################################
	// Reference model
	// ########################################################################

	logic       m_bypass;
	logic       m_rst;
	logic       m_cke;
	tim_cfg_t   m_tim;
	sdram_adr_t m_adr;     // Sticky command address.
	sdram_ba_t  m_ba;
	logic       m_psready;
	logic [1:0] m_pll;     // Value on the pins, synced later.
	sdram_cmd_t pad_q[$];  // Expected pads, one entry per cycle.

	function automatic sdram_cmd_t make_cmd(input logic [3:0] lines, input sdram_adr_t adr,
		input sdram_ba_t ba);
		sdram_cmd_t c;
		{c.cs_n, c.ras_n, c.cas_n, c.we_n} = lines;
		c.adr = adr;
		c.ba  = ba;
		return c;
	endfunction

	function automatic sdram_cmd_t pad_now();
		return make_cmd({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n}, sdram_adr, sdram_ba);
	endfunction

	function automatic csr_addr_t in_bank_addr(input logic [1:0] idx);
		return {CSR_BANK, 8'($urandom), idx}; // Middle bits are don't care.
	endfunction

	function automatic csr_addr_t other_bank_addr(input logic [1:0] idx);
		return {CSR_BANK ^ 4'($urandom_range(15, 1)), 8'($urandom), idx};
	endfunction

	function automatic void model_write(input csr_addr_t addr, input csr_data_t data);
		if (addr[13:10] == CSR_BANK) begin
			case (addr[1:0])
				REG_MODE: {m_cke, m_rst, m_bypass} = data[2:0];
				REG_CMD: begin
					m_adr = data[16:4];
					m_ba  = data[18:17];
				end
				REG_TIM: m_tim = tim_cfg_t'(data[23:0]);
				default: begin
					if (data[4])
						m_psready = 1'b0; // Phase shift restarted.
				end
			endcase
		end
	endfunction

	function automatic csr_data_t model_read(input csr_addr_t addr);
		csr_data_t d;
		d = '0;
		if (addr[13:10] == CSR_BANK) begin
			case (addr[1:0])
				REG_MODE: d[2:0] = {m_cke, m_rst, m_bypass};
				REG_CMD: begin
					d[16:4]  = m_adr;
					d[18:17] = m_ba;
				end
				REG_TIM: d[23:0] = m_tim;
				default: begin
					d[8:7] = m_pll;
					d[6]   = m_psready;
				end
			endcase
		end
		return d;
	endfunction

	// Full refresh round after a PRECHARGE ALL, ending on the next one.
	function automatic void push_refresh_cycle();
		repeat (m_tim.rp) pad_q.push_back(make_cmd(CMD_NOP, '0, '0));
		pad_q.push_back(make_cmd(CMD_AUTO_REFRESH, '0, '0));
		repeat (int'(m_tim.rfc) + int'(m_tim.refi) + 1)
			pad_q.push_back(make_cmd(CMD_NOP, '0, '0));
		pad_q.push_back(make_cmd(CMD_PRECHARGE_ALL, 13'h0400, '0));
	endfunction

	// ########################################################################
	// Checks
	// ########################################################################

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
	endtask

	task automatic check_cmd(input string name, input sdram_cmd_t got, input sdram_cmd_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
	endtask

	task automatic check_tim(input string name, input tim_cfg_t got, input tim_cfg_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
	endtask

	always @(negedge sys_clk) begin
		if (dut_i.props_i.err_count != 0)
			abort_run("A concurrent assertion on the DUT failed.");
	end

	// ########################################################################
	// Bus and pad tasks
	// ########################################################################

	task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
		@(posedge sys_clk);
		csr_a  <= addr;
		csr_we <= 1'b1;
		csr_di <= data;
		@(posedge sys_clk); // DUT takes the write here.
		csr_we <= 1'b0;
		model_write(addr, data);
	endtask

	task automatic csr_read_check(input csr_addr_t addr);
		csr_data_t exp;
		exp = model_read(addr);
		@(posedge sys_clk);
		csr_a  <= addr;
		csr_we <= 1'b0;
		@(posedge sys_clk); // Read data registered here.
		@(negedge sys_clk);
		check_csr("csr_do", csr_do, exp);
	endtask

	task automatic drain_pad_queue();
		sdram_cmd_t exp;
		while (pad_q.size() > 0) begin
			@(negedge sys_clk);
			exp = pad_q.pop_front();
			check_cmd("pad_cmd", pad_now(), exp);
		end
	endtask

	// CKE reaches the pads one cycle after the register.
	task automatic mode_write_check(input csr_data_t data);
		logic old_cke;
		old_cke = m_cke;
		csr_write(in_bank_addr(REG_MODE), data);
		@(negedge sys_clk);
		check_flag("sdram_cke", sdram_cke, old_cke);
		@(negedge sys_clk);
		check_flag("sdram_cke", sdram_cke, m_cke);
	endtask

	// Software command in bypass, pads before, on and after the slot.
	task automatic sw_cmd_check(input csr_data_t data);
		sdram_cmd_t hit;
		hit.cs_n  = ~data[0];
		hit.we_n  = ~data[1];
		hit.cas_n = ~data[2];
		hit.ras_n = ~data[3];
		hit.adr   = data[16:4];
		hit.ba    = data[18:17];
		if (m_rst) begin
			repeat (3) pad_q.push_back(make_cmd(CMD_NOP, '0, '0)); // Held idle.
		end else begin
			pad_q.push_back(make_cmd(CMD_NOP, m_adr, m_ba));
			pad_q.push_back(hit);
			pad_q.push_back(make_cmd(CMD_NOP, hit.adr, hit.ba));
		end
		csr_write(in_bank_addr(REG_CMD), data);
		drain_pad_queue();
	endtask

	task automatic phy_write_check(input csr_data_t data);
		csr_write(in_bank_addr(REG_PHY), data);
		@(negedge sys_clk);
		check_flag("idelay_rst", idelay_rst, data[0]);
		check_flag("idelay_ce", idelay_ce, data[1]);
		check_flag("idelay_inc", idelay_inc, data[2]);
		check_flag("idelay_cal", idelay_cal, data[3]);
		check_flag("dqs_psen", dqs_psen, data[4]);
		check_flag("dqs_psincdec", dqs_psincdec, data[5]);
		@(negedge sys_clk); // Pulses gone, level stays.
		check_flag("idelay_rst", idelay_rst, 1'b0);
		check_flag("idelay_ce", idelay_ce, 1'b0);
		check_flag("idelay_inc", idelay_inc, 1'b0);
		check_flag("idelay_cal", idelay_cal, data[3]);
		check_flag("dqs_psen", dqs_psen, 1'b0);
		check_flag("dqs_psincdec", dqs_psincdec, 1'b0);
	endtask

	task automatic wait_precharge(input int limit);
		sdram_cmd_t c;
		int         n;
		n = 0;
		@(negedge sys_clk);
		c = pad_now();
		while ({c.cs_n, c.ras_n, c.cas_n, c.we_n} != CMD_PRECHARGE_ALL) begin
			if (n == limit)
				abort_run("Timeout waiting for PRECHARGE ALL on the SDRAM pads.");
			n++;
			@(negedge sys_clk);
			c = pad_now();
		end
		check_cmd("pad_cmd", c, make_cmd(CMD_PRECHARGE_ALL, 13'h0400, '0));
	endtask

	// ########################################################################
	// Stimulus
	// ########################################################################

	initial begin
		csr_data_t  d;
		tim_cfg_t   t;
		logic [1:0] v;
		int         op;
		op = $urandom(3493); // Seed once.
		m_bypass  = 1'b1;
		m_rst     = 1'b1;
		m_cke     = 1'b0;
		m_tim.rp  = 3'd2;
		m_tim.rcd = 3'd2;
		m_tim.cas = 1'b0;
		m_tim.refi = 11'd620;
		m_tim.rfc = 4'd6;
		m_tim.wr  = 2'd2;
		m_adr     = '0;
		m_ba      = '0;
		m_psready = 1'b0;
		m_pll     = 2'b00;
		repeat (5) @(posedge sys_clk);
		sys_rst <= 1'b0;

		// Reset values.
		@(negedge sys_clk);
		check_tim("tim", tim, m_tim);
		check_flag("sdram_cke", sdram_cke, 1'b0);
		check_flag("idelay_cal", idelay_cal, 1'b0);
		check_cmd("pad_cmd", pad_now(), make_cmd(CMD_NOP, '0, '0));
		csr_read_check(in_bank_addr(REG_MODE));
		csr_read_check(in_bank_addr(REG_TIM));
		csr_read_check(in_bank_addr(REG_PHY));
		csr_read_check(in_bank_addr(REG_CMD));

		// Random register traffic, in and out of the bank.
		repeat (40) begin
			op = $urandom_range(4, 0);
			case (op)
				0: csr_write(in_bank_addr(REG_MODE), $urandom);
				1: begin
					d = $urandom;
					csr_write(in_bank_addr(REG_TIM), d);
					@(negedge sys_clk);
					check_tim("tim", tim, m_tim);
				end
				2: csr_read_check(in_bank_addr(2'($urandom)));
				3: csr_read_check(other_bank_addr(2'($urandom)));
				default: begin
					csr_write(other_bank_addr(2'($urandom)), $urandom);
					@(negedge sys_clk);
					check_tim("tim", tim, m_tim); // Untouched.
				end
			endcase
		end
		csr_read_check(in_bank_addr(REG_MODE));
		csr_read_check(in_bank_addr(REG_TIM));
		csr_read_check(in_bank_addr(REG_PHY));

		// Bypass, software commands reach the pads.
		mode_write_check(32'h5);
		repeat (8) sw_cmd_check($urandom);
		csr_read_check(in_bank_addr(REG_CMD));
		mode_write_check(32'h3); // SDRAM reset again.
		repeat (3) sw_cmd_check($urandom);
		csr_read_check(in_bank_addr(REG_CMD));

		// Auto refresh with small random timings.
		t.rp   = 3'($urandom_range(7, 0));
		t.rcd  = 3'($urandom);
		t.cas  = 1'($urandom);
		t.refi = 11'($urandom_range(40, 12));
		t.rfc  = 4'($urandom);
		t.wr   = 2'($urandom);
		csr_write(in_bank_addr(REG_TIM), {8'($urandom), t});
		@(negedge sys_clk);
		check_tim("tim", tim, m_tim);
		mode_write_check(32'h4); // Out of bypass and reset.
		wait_precharge(int'(m_tim.refi) + 20);
		fork
			begin
				repeat (3) begin
					repeat ($urandom_range(10, 2)) @(posedge sys_clk);
					csr_write(in_bank_addr(REG_CMD), $urandom); // Must stay off the pads.
				end
			end
			begin
				repeat (3) begin
					push_refresh_cycle();
					drain_pad_queue();
				end
			end
		join
		csr_read_check(in_bank_addr(REG_CMD));
		mode_write_check(32'h7);

		// PHY strobes, psready and PLL status.
		repeat (6) phy_write_check($urandom);
		csr_read_check(in_bank_addr(REG_PHY));
		@(posedge sys_clk);
		dqs_psdone <= 1'b1;
		@(posedge sys_clk);
		dqs_psdone <= 1'b0;
		m_psready = 1'b1;
		csr_read_check(in_bank_addr(REG_PHY));
		phy_write_check(($urandom & 32'h2f) | 32'h10);
		csr_read_check(in_bank_addr(REG_PHY));
		repeat (3) begin
			v = 2'($urandom);
			@(posedge sys_clk);
			pll_stat <= v;
			m_pll = v;
			repeat (3) @(posedge sys_clk); // Through the synchronizer.
			csr_read_check(in_bank_addr(REG_PHY));
		end

		if (dut_i.props_i.err_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run("A concurrent assertion on the DUT failed.");
		end
	end

endmodule

/* sim.f */
verilog/sdram_pkg.sv
verilog/sdram_ctlif.sv
verilog/sdram_refresh.sv
verilog/sdram_cmd_out.sv
verilog/sdram_ctrl_top.sv
verif/sdram_ctrl_properties.sv
verif/tb_sdram_ctrl.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - verilog/sdram_pkg.sv
  - verilog/sdram_ctlif.sv
  - verilog/sdram_refresh.sv
  - verilog/sdram_cmd_out.sv
  - verilog/sdram_ctrl_top.sv
  - target: simulation
    files:
      - verif/sdram_ctrl_properties.sv
      - verif/tb_sdram_ctrl.sv
